//--- src/mips_pkg.sv
package mips_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0] mem_word_t;

    // Primary opcodes, instruction bits 31:26
    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_j     = 6'h02;
    localparam logic [5:0] op_jal   = 6'h03;
    localparam logic [5:0] op_beq   = 6'h04;
    localparam logic [5:0] op_bne   = 6'h05;
    localparam logic [5:0] op_addi  = 6'h08;
    localparam logic [5:0] op_addiu = 6'h09;
    localparam logic [5:0] op_slti  = 6'h0a;
    localparam logic [5:0] op_sltiu = 6'h0b;
    localparam logic [5:0] op_andi  = 6'h0c;
    localparam logic [5:0] op_ori   = 6'h0d;
    localparam logic [5:0] op_xori  = 6'h0e;
    localparam logic [5:0] op_lui   = 6'h0f;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2b;

    // Function codes of R-type instructions, bits 5:0
    localparam logic [5:0] fn_sll     = 6'h00;
    localparam logic [5:0] fn_srl     = 6'h02;
    localparam logic [5:0] fn_sra     = 6'h03;
    localparam logic [5:0] fn_jr      = 6'h08;
    localparam logic [5:0] fn_syscall = 6'h0c;
    localparam logic [5:0] fn_add     = 6'h20;
    localparam logic [5:0] fn_addu    = 6'h21;
    localparam logic [5:0] fn_sub     = 6'h22;
    localparam logic [5:0] fn_subu    = 6'h23;
    localparam logic [5:0] fn_and     = 6'h24;
    localparam logic [5:0] fn_or      = 6'h25;
    localparam logic [5:0] fn_xor     = 6'h26;
    localparam logic [5:0] fn_nor     = 6'h27;
    localparam logic [5:0] fn_slt     = 6'h2a;
    localparam logic [5:0] fn_sltu    = 6'h2b;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
        alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    typedef struct packed {
        logic    reg_dest;
        logic    reg_write_enable;
        logic    alu_src;
        alu_op_e alu_operation;
        logic    mem_or_reg;
        logic    mem_write;
        logic    pc_or_mem;
        logic    branch;
        logic    branch_on_ne;
        logic    jump;
        logic    jump_register;
        logic    shift_amount_needed;
        logic    is_unsigned;
    } ctrl_t;

    localparam mem_word_t reset_pc = '0;

    // jal writes its return address here
    localparam logic [reg_addr_w-1:0] link_reg = 5'd31;

endpackage

//--- src/alu.sv
`timescale 1ns/10ps

module alu import mips_pkg::*; (
    input  mem_word_t input1,
    input  mem_word_t input2,
    input  alu_op_e   alu_operation,
    output mem_word_t result,
    output logic      zero,
    output logic      negative
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // Shift amount arrives on the first operand, the value to shift on the second
    assign shamt = input1[4:0];

    assign lt_signed   = $signed(input1) < $signed(input2);
    assign lt_unsigned = input1 < input2;

    always_comb begin
        unique case (alu_operation)
            alu_add: result = input1 + input2;
            alu_sub: result = input1 - input2;
            alu_and: result = input1 & input2;
            alu_or:  result = input1 | input2;
            alu_xor: result = input1 ^ input2;
            alu_nor: result = ~(input1 | input2);
            alu_slt: begin
                result = '0;
                result[0] = lt_signed;
            end
            alu_sltu: begin
                result = '0;
                result[0] = lt_unsigned;
            end
            alu_sll: result = input2 << shamt;
            alu_srl: result = input2 >> shamt;
            alu_sra: result = $signed(input2) >>> shamt;
            alu_lui: result = {input2[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);
    assign negative = result[xlen-1];

endmodule

//--- src/regfile.sv
`timescale 1ns/10ps

module regfile import mips_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [reg_addr_w-1:0] rs_num,
    input  logic [reg_addr_w-1:0] rt_num,
    input  logic [reg_addr_w-1:0] rd_num,
    input  mem_word_t             rd_data,
    input  logic                  rd_we,
    output mem_word_t             rs_data,
    output mem_word_t             rt_data
);

    localparam int num_regs = 1 << reg_addr_w;

    mem_word_t regs [num_regs];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd_num != '0) begin
            regs[rd_num] <= rd_data;
        end
    end

    // Register 0 is never written, so it reads as zero without a bypass
    assign rs_data = regs[rs_num];
    assign rt_data = regs[rt_num];

    assert property (@(posedge clk) disable iff (!rst_n)
        rd_we && rd_num == '0 |=> regs[0] == '0);

endmodule

//--- src/pc_unit.sv
`timescale 1ns/10ps

module pc_unit import mips_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      hold,
    input  mem_word_t inst,
    input  mem_word_t rs_data,
    input  logic      take_branch,
    input  logic      jump,
    input  logic      jump_register,
    output mem_word_t pc,
    output mem_word_t pc_plus4
);

    mem_word_t branch_offset;
    mem_word_t branch_target;
    mem_word_t jump_target;
    mem_word_t pc_next;

    assign pc_plus4 = pc + 32'd4;

    // Branch offset counts words relative to the following instruction
    assign branch_offset = {{(xlen-18){inst[15]}}, inst[15:0], 2'b00};
    assign branch_target = pc_plus4 + branch_offset;

    // Jumps stay inside the current 256 MB region
    assign jump_target = {pc_plus4[xlen-1:xlen-4], inst[25:0], 2'b00};

    always_comb begin
        if (jump_register) begin
            pc_next = rs_data;
        end else if (jump) begin
            pc_next = jump_target;
        end else if (take_branch) begin
            pc_next = branch_target;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else if (!hold) begin
            pc <= pc_next;
        end
    end

    // Holds as long as jr only targets addresses written by jal
    assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00);

endmodule

//--- src/control_unit.sv
`timescale 1ns/10ps

module control_unit import mips_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  mem_word_t inst,
    input  logic      zero,
    output ctrl_t     ctrl,
    output logic      take_branch,
    output logic      halted
);

    typedef enum logic {st_run, st_halted} state_e;

    state_e     state;
    ctrl_t      dec;
    logic [5:0] opcode;
    logic [5:0] funct;
    logic       is_syscall;

    assign opcode = inst[31:26];
    assign funct  = inst[5:0];
    assign is_syscall = (opcode == op_rtype) && (funct == fn_syscall);

    always_comb begin
        dec = '0;
        dec.alu_operation = alu_add;
        unique case (opcode)
            op_rtype: begin
                dec.reg_dest = 1'b1;
                dec.reg_write_enable = 1'b1;
                unique case (funct)
                    fn_add, fn_addu: dec.alu_operation = alu_add;
                    fn_sub, fn_subu: dec.alu_operation = alu_sub;
                    fn_and:  dec.alu_operation = alu_and;
                    fn_or:   dec.alu_operation = alu_or;
                    fn_xor:  dec.alu_operation = alu_xor;
                    fn_nor:  dec.alu_operation = alu_nor;
                    fn_slt:  dec.alu_operation = alu_slt;
                    fn_sltu: dec.alu_operation = alu_sltu;
                    fn_sll, fn_srl, fn_sra: begin
                        dec.shift_amount_needed = 1'b1;
                        dec.alu_operation = (funct == fn_sll) ? alu_sll :
                                            (funct == fn_srl) ? alu_srl : alu_sra;
                    end
                    fn_jr: begin
                        dec.reg_write_enable = 1'b0;
                        dec.jump_register = 1'b1;
                    end
                    // syscall and unknown functs write nothing
                    default: dec.reg_write_enable = 1'b0;
                endcase
            end
            op_j: dec.jump = 1'b1;
            op_jal: begin
                dec.jump = 1'b1;
                dec.pc_or_mem = 1'b1;
                dec.reg_write_enable = 1'b1;
            end
            op_beq, op_bne: begin
                dec.branch = 1'b1;
                dec.branch_on_ne = (opcode == op_bne);
                dec.alu_operation = alu_sub;
            end
            op_addi, op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui: begin
                dec.alu_src = 1'b1;
                dec.reg_write_enable = 1'b1;
                dec.is_unsigned = (opcode == op_andi) || (opcode == op_ori) ||
                                  (opcode == op_xori) || (opcode == op_lui);
                dec.alu_operation = (opcode == op_slti)  ? alu_slt  :
                                    (opcode == op_sltiu) ? alu_sltu :
                                    (opcode == op_andi)  ? alu_and  :
                                    (opcode == op_ori)   ? alu_or   :
                                    (opcode == op_xori)  ? alu_xor  :
                                    (opcode == op_lui)   ? alu_lui  : alu_add;
            end
            op_lw: begin
                dec.alu_src = 1'b1;
                dec.reg_write_enable = 1'b1;
                dec.mem_or_reg = 1'b1;
            end
            op_sw: begin
                dec.alu_src = 1'b1;
                dec.mem_write = 1'b1;
            end
            default: ;
        endcase
    end

    // A halted core must not change any architectural state
    always_comb begin
        ctrl = dec;
        ctrl.reg_write_enable = dec.reg_write_enable && (state == st_run);
        ctrl.mem_write = dec.mem_write && (state == st_run) && rst_n;
    end

    assign take_branch = ctrl.branch && (zero ^ ctrl.branch_on_ne);
    assign halted = (state == st_halted);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_run;
        end else if (state == st_run && is_syscall) begin
            state <= st_halted;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({ctrl.branch, ctrl.jump, ctrl.jump_register}));

    // Only reset leaves the halted state
    assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted);

endmodule

//--- src/data_path.sv
`timescale 1ns/10ps

module data_path import mips_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  mem_word_t       inst,
    input  ctrl_t           ctrl,
    input  logic            take_branch,
    input  logic            halted,
    output mem_word_t       inst_addr,
    output mem_word_t       mem_addr,
    output logic [3:0][7:0] mem_wdata,
    input  logic [3:0][7:0] mem_rdata,
    output logic            mem_write,
    output logic            zero,
    output logic            negative
);

    logic [reg_addr_w-1:0] rs_num;
    logic [reg_addr_w-1:0] rt_num;
    logic [reg_addr_w-1:0] rd_inst_num;
    logic [reg_addr_w-1:0] dest_num;

    mem_word_t rs_data;
    mem_word_t rt_data;
    mem_word_t wb_data;
    mem_word_t imm_ext;
    mem_word_t shamt_ext;
    mem_word_t alu_in1;
    mem_word_t alu_in2;
    mem_word_t alu_result;
    mem_word_t load_word;
    mem_word_t pc;
    mem_word_t pc_plus4;

    assign rs_num      = inst[25:21];
    assign rt_num      = inst[20:16];
    assign rd_inst_num = inst[15:11];

    // jal overrides the encoded destination with the link register
    always_comb begin
        if (ctrl.pc_or_mem) begin
            dest_num = link_reg;
        end else if (ctrl.reg_dest) begin
            dest_num = rd_inst_num;
        end else begin
            dest_num = rt_num;
        end
    end

    assign imm_ext = ctrl.is_unsigned ? {{(xlen-16){1'b0}}, inst[15:0]}
                                      : {{(xlen-16){inst[15]}}, inst[15:0]};
    assign shamt_ext = {{(xlen-5){1'b0}}, inst[10:6]};

    assign alu_in1 = ctrl.shift_amount_needed ? shamt_ext : rs_data;
    assign alu_in2 = ctrl.alu_src ? imm_ext : rt_data;

    // Lane 0 sits in bits 7:0, so the packed bytes already form the word
    assign load_word = mem_rdata;
    assign mem_wdata = rt_data;
    assign mem_addr  = alu_result;
    assign mem_write = ctrl.mem_write;
    assign inst_addr = pc;

    always_comb begin
        if (ctrl.pc_or_mem) begin
            wb_data = pc_plus4;
        end else if (ctrl.mem_or_reg) begin
            wb_data = load_word;
        end else begin
            wb_data = alu_result;
        end
    end

    alu alu_i (
        .input1        (alu_in1),
        .input2        (alu_in2),
        .alu_operation (ctrl.alu_operation),
        .result        (alu_result),
        .zero          (zero),
        .negative      (negative)
    );

    regfile regfile_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_num  (rs_num),
        .rt_num  (rt_num),
        .rd_num  (dest_num),
        .rd_data (wb_data),
        .rd_we   (ctrl.reg_write_enable),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    pc_unit pc_unit_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .hold          (halted),
        .inst          (inst),
        .rs_data       (rs_data),
        .take_branch   (take_branch),
        .jump          (ctrl.jump),
        .jump_register (ctrl.jump_register),
        .pc            (pc),
        .pc_plus4      (pc_plus4)
    );

endmodule

//--- src/mips_core.sv
`timescale 1ns/10ps

module mips_core import mips_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  mem_word_t       inst,
    output mem_word_t       inst_addr,
    output mem_word_t       mem_addr,
    output logic [3:0][7:0] mem_wdata,
    input  logic [3:0][7:0] mem_rdata,
    output logic            mem_write,
    output logic            halted
);

    ctrl_t ctrl;
    logic  zero;
    logic  take_branch;

    control_unit control_unit_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst        (inst),
        .zero        (zero),
        .ctrl        (ctrl),
        .take_branch (take_branch),
        .halted      (halted)
    );

    // The negative flag has no consumer among the supported branches
    data_path data_path_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst        (inst),
        .ctrl        (ctrl),
        .take_branch (take_branch),
        .halted      (halted),
        .inst_addr   (inst_addr),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata),
        .mem_write   (mem_write),
        .zero        (zero),
        .negative    ()
    );

endmodule

//--- sim/mips_checker.sv
`timescale 1ns/10ps

module mips_checker import mips_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  mem_word_t           inst,
    input  mem_word_t           inst_addr,
    input  mem_word_t           mem_addr,
    input  logic [3:0][7:0]     mem_wdata,
    input  logic                mem_write,
    input  logic                halted,
    input  logic [255:0][31:0]  dmem_init,
    output int                  errors
);

    mem_word_t regs [32];
    mem_word_t dmem [256];
    mem_word_t pc;
    logic      done;
    logic      lost;

    initial errors = 0;

    task automatic compare(input string name, input mem_word_t expected,
                           input mem_word_t actual, output logic bad);
        bad = (expected !== actual);
        if (bad) begin
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // Executes the instruction at the model PC against the model state
    task automatic step();
        logic [5:0] op;
        logic [5:0] fn;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] dest;
        logic [4:0] sh;
        logic       wr;
        logic       st;
        logic       bad;
        mem_word_t  a;
        mem_word_t  b;
        mem_word_t  se;
        mem_word_t  ze;
        mem_word_t  pc4;
        mem_word_t  npc;
        mem_word_t  val;
        mem_word_t  addr;
        op = inst[31:26];
        fn = inst[5:0];
        rs = inst[25:21];
        rt = inst[20:16];
        sh = inst[10:6];
        a = regs[rs];
        b = regs[rt];
        se = {{16{inst[15]}}, inst[15:0]};
        ze = {16'h0000, inst[15:0]};
        pc4 = pc + 32'd4;
        npc = pc4;
        addr = a + se;
        dest = rt;
        val = '0;
        wr = 1'b1;
        st = 1'b0;
        case (op)
            op_rtype: begin
                dest = inst[15:11];
                case (fn)
                    fn_add, fn_addu: val = a + b;
                    fn_sub, fn_subu: val = a - b;
                    fn_and:  val = a & b;
                    fn_or:   val = a | b;
                    fn_xor:  val = a ^ b;
                    fn_nor:  val = ~(a | b);
                    fn_slt:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    fn_sltu: val = (a < b) ? 32'd1 : 32'd0;
                    fn_sll:  val = b << sh;
                    fn_srl:  val = b >> sh;
                    fn_sra:  val = $signed(b) >>> sh;
                    fn_jr: begin
                        wr = 1'b0;
                        npc = a;
                    end
                    fn_syscall: begin
                        wr = 1'b0;
                        done = 1'b1;
                    end
                    default: wr = 1'b0;
                endcase
            end
            op_addi, op_addiu: val = a + se;
            op_slti:  val = ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
            op_sltiu: val = (a < se) ? 32'd1 : 32'd0;
            op_andi:  val = a & ze;
            op_ori:   val = a | ze;
            op_xori:  val = a ^ ze;
            op_lui:   val = {inst[15:0], 16'h0000};
            op_lw:    val = dmem[addr[9:2]];
            op_sw: begin
                wr = 1'b0;
                st = 1'b1;
            end
            op_beq, op_bne: begin
                wr = 1'b0;
                if ((a == b) ^ (op == op_bne)) npc = pc4 + (se << 2);
            end
            op_j: begin
                wr = 1'b0;
                npc = {pc4[31:28], inst[25:0], 2'b00};
            end
            op_jal: begin
                dest = link_reg;
                val = pc4;
                npc = {pc4[31:28], inst[25:0], 2'b00};
            end
            default: wr = 1'b0;
        endcase
        compare("mem_write", {31'b0, st}, {31'b0, mem_write}, bad);
        if (st) begin
            compare("mem_addr", addr, mem_addr, bad);
            compare("mem_wdata", b, mem_wdata, bad);
            dmem[addr[9:2]] = b;
        end
        if (wr && dest != 5'd0) regs[dest] = val;
        pc = npc;
    endtask

    always @(negedge clk) begin
        logic bad;
        if (!rst_n) begin
            pc = reset_pc;
            done = 1'b0;
            lost = 1'b0;
            for (int i = 0; i < 32; i++) regs[i] = '0;
            for (int i = 0; i < 256; i++) dmem[i] = dmem_init[i];
        end else if (!lost) begin
            if (done && halted !== 1'b1) begin
                $display("halted did not rise after syscall at time %0t", $time);
                errors++;
                lost = 1'b1;
            end else if (!done && halted !== 1'b0) begin
                $display("halted rose before any syscall at time %0t", $time);
                errors++;
                lost = 1'b1;
            end else begin
                compare("inst_addr", pc, inst_addr, bad);
                if (bad) begin
                    lost = 1'b1;
                end else if (done) begin
                    compare("mem_write", '0, {31'b0, mem_write}, bad);
                end else begin
                    step();
                end
            end
        end
    end

endmodule

//--- sim/tb_mips.sv
`timescale 1ns/10ps

module tb_mips import mips_pkg::*; ();

    localparam int num_tests = 12;
    localparam int max_len = 64;
    localparam int hold_cycles = 10;
    localparam int reset_cycles = 3;
    localparam int cycle_limit = num_tests * (max_len + hold_cycles + 2 * reset_cycles);

    localparam logic [12:0][5:0] alu_functs = {fn_add, fn_addu, fn_sub, fn_subu, fn_and,
        fn_or, fn_xor, fn_nor, fn_slt, fn_sltu, fn_sll, fn_srl, fn_sra};
    localparam logic [7:0][5:0] imm_ops = {op_addi, op_addiu, op_slti, op_sltiu,
        op_andi, op_ori, op_xori, op_lui};

    logic               clk;
    logic               rst_n;
    mem_word_t          inst;
    mem_word_t          inst_addr;
    mem_word_t          mem_addr;
    logic [3:0][7:0]    mem_wdata;
    logic [3:0][7:0]    mem_rdata;
    logic               mem_write;
    logic               halted;
    mem_word_t          imem [256];
    logic [7:0]         dbytes [1024];
    logic [255:0][31:0] dmem_init;
    bit                 targeted [max_len];
    integer             seed;
    int                 errors;
    int                 cycles = 0;

    mips_core mips_core_i (.clk(clk), .rst_n(rst_n), .inst(inst), .inst_addr(inst_addr),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
        .mem_write(mem_write), .halted(halted));

    mips_checker mips_checker_i (.clk(clk), .rst_n(rst_n), .inst(inst),
        .inst_addr(inst_addr), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_write(mem_write), .halted(halted), .dmem_init(dmem_init), .errors(errors));

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Both memories answer in the same cycle; byte lane k sits at address + k
    assign inst = imem[inst_addr[9:2]];

    always_comb begin
        for (int k = 0; k < 4; k++) mem_rdata[k] = dbytes[mem_addr[9:2] * 4 + k];
    end

    always @(posedge clk) begin
        if (rst_n === 1'b1 && mem_write === 1'b1) begin
            for (int k = 0; k < 4; k++) dbytes[mem_addr[9:2] * 4 + k] <= mem_wdata[k];
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic int rand_below(int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    function automatic mem_word_t enc_r(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                        logic [4:0] sh, logic [5:0] fn);
        return {op_rtype, rs, rt, rd, sh, fn};
    endfunction

    function automatic mem_word_t enc_i(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                        logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic mem_word_t rand_alu();
        if (rand_below(2) == 0) begin
            return enc_r(rand_below(32), rand_below(32), 2 + rand_below(29), rand_below(32),
                         alu_functs[rand_below(13)]);
        end
        return enc_i(imm_ops[rand_below(8)], rand_below(32), 2 + rand_below(29),
                     rand_below(65536));
    endfunction

    // Register 1 is the data base at 0x100, registers 31 and 30 belong to jal and jr
    task automatic gen_program();
        int len;
        int k;
        int kind;
        int skip;
        // Words past the program are stores, which a halted core must never perform
        for (int i = 0; i < 256; i++) imem[i] = enc_i(op_sw, 5'd1, 5'(i), 16'(i * 4));
        for (int i = 0; i < max_len; i++) targeted[i] = 1'b0;
        len = 24 + rand_below(max_len - 23);
        imem[0] = enc_i(op_lui, 5'd0, 5'd1, 16'h0000);
        imem[1] = enc_i(op_ori, 5'd1, 5'd1, 16'h0100);
        k = 2;
        while (k < len - 1) begin
            kind = rand_below(12);
            skip = rand_below(4);
            if (kind >= 4 && kind < 6) begin
                imem[k] = enc_i(op_sw, 5'd1, rand_below(32), rand_below(32) * 4);
                k++;
            end else if (kind >= 6 && kind < 8) begin
                imem[k] = enc_i(op_lw, 5'd1, 2 + rand_below(29), rand_below(32) * 4);
                k++;
            end else if (kind >= 8 && kind < 10 && k + 1 + skip <= len - 1) begin
                imem[k] = enc_i(kind == 8 ? op_beq : op_bne, rand_below(32), rand_below(32),
                                skip);
                targeted[k + 1 + skip] = 1'b1;
                k++;
            end else if (kind == 10 && k + 1 + skip <= len - 1) begin
                imem[k] = {op_j, 26'(k + 1 + skip)};
                targeted[k + 1 + skip] = 1'b1;
                k++;
            end else if (kind == 11 && k + 4 + skip <= len - 1 && !targeted[k + 1] &&
                         !targeted[k + 2] && !targeted[k + 3]) begin
                // jal skips one slot, then jr returns past its own position
                imem[k] = {op_jal, 26'(k + 2)};
                imem[k + 1] = rand_alu();
                imem[k + 2] = enc_i(op_addiu, 5'd31, 5'd30, (3 + skip) * 4);
                imem[k + 3] = enc_r(5'd30, 5'd0, 5'd0, 5'd0, fn_jr);
                targeted[k + 4 + skip] = 1'b1;
                k += 4;
            end else begin
                imem[k] = rand_alu();
                k++;
            end
        end
        imem[len - 1] = enc_r(5'd0, 5'd0, 5'd0, 5'd0, fn_syscall);
    endtask

    initial begin
        int passed;
        int failed;
        int errors_before;
        int n;
        rst_n = 1'b0;
        seed = 32'h4947;
        passed = 0;
        failed = 0;
        for (int t = 0; t < num_tests; t++) begin
            gen_program();
            for (int i = 0; i < 256; i++) begin
                dmem_init[i] = (32'h9e37_79b9 * (i + 1)) ^ (t << 24);
                for (int k = 0; k < 4; k++) dbytes[i * 4 + k] = dmem_init[i][8 * k +: 8];
            end
            @(posedge clk);
            rst_n <= 1'b0;
            repeat (reset_cycles) @(posedge clk);
            rst_n <= 1'b1;
            errors_before = errors;
            n = 0;
            @(negedge clk);
            while (halted !== 1'b1 && n < max_len + 2) begin
                @(negedge clk);
                n++;
            end
            if (halted !== 1'b1) begin
                $display("test %0d: the core never halted", t);
                failed++;
            end else begin
                repeat (hold_cycles) @(negedge clk);
                @(posedge clk);
                if (errors == errors_before) begin
                    $display("test %0d passed", t);
                    passed++;
                end else begin
                    $display("test %0d failed with %0d errors", t, errors - errors_before);
                    failed++;
                end
            end
        end
        $display("%0d tests passed, %0d tests failed, %0d errors", passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- files.f
src/mips_pkg.sv
src/alu.sv
src/regfile.sv
src/pc_unit.sv
src/control_unit.sv
src/data_path.sv
src/mips_core.sv
sim/mips_checker.sv
sim/tb_mips.sv
